// ==== apb_periph_pkg.sv ====
`default_nettype none

package apb_periph_pkg;

   // Bus widths
   typedef logic [31:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   localparam int unsigned NUM_GPIO = 32;
   typedef logic [NUM_GPIO-1:0] gpio_vec_t;

   localparam int unsigned NUM_PWM = 4;
   typedef logic [15:0] pwm_cnt_t;

   // Address bits that pick one of the slaves
   localparam int unsigned SLOT_LSB = 12;
   localparam int unsigned SLOT_MSB = 15;
   typedef logic [SLOT_MSB-SLOT_LSB:0] apb_slot_t;
   typedef logic [SLOT_LSB-1:0]        apb_ofs_t;

   localparam apb_slot_t SLOT_GPIO = 4'd0;
   localparam apb_slot_t SLOT_PWM  = 4'd1;
   localparam apb_slot_t SLOT_CTRL = 4'd2;

   localparam apb_ofs_t GPIO_DIR_OFS = 12'h000;
   localparam apb_ofs_t GPIO_OUT_OFS = 12'h004;
   localparam apb_ofs_t GPIO_IN_OFS  = 12'h008;

   localparam apb_ofs_t PWM_PERIOD_OFS = 12'h000;
   localparam apb_ofs_t PWM_CTRL_OFS   = 12'h004;
   localparam apb_ofs_t PWM_COUNT_OFS  = 12'h008;
   // First of NUM_PWM consecutive threshold words
   localparam apb_ofs_t PWM_TH_OFS     = 12'h010;

   localparam apb_ofs_t CTRL_REG_OFS     = 12'h000;
   localparam apb_ofs_t CTRL_VERSION_OFS = 12'h004;

   localparam int unsigned CTRL_FETCH_BIT   = 0;
   localparam int unsigned CTRL_SA_BOOT_BIT = 1;
   localparam int unsigned CTRL_CL_RSTN_BIT = 2;

   localparam apb_data_t CTRL_VERSION = 32'h4150_0100;

endpackage

`default_nettype wire

// ==== apb_if.sv ====
`default_nettype none

interface apb_if;
   import apb_periph_pkg::*;

   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   modport master (
      output psel, penable, pwrite, paddr, pwdata,
      input  prdata, pready, pslverr
   );

   modport slave (
      input  psel, penable, pwrite, paddr, pwdata,
      output prdata, pready, pslverr
   );

endinterface

`default_nettype wire

// ==== apb_periph_demux.sv ====
`default_nettype none

module apb_periph_demux (
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  apb_periph_pkg::apb_addr_t paddr_i,
   input  apb_periph_pkg::apb_data_t pwdata_i,
   output apb_periph_pkg::apb_data_t prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,
   apb_if.master                     gpio_bus,
   apb_if.master                     pwm_bus,
   apb_if.master                     ctrl_bus
);
   import apb_periph_pkg::*;

   apb_slot_t slot;

   assign slot = paddr_i[SLOT_MSB:SLOT_LSB];

   // Only the addressed slave is selected
   assign gpio_bus.psel = psel_i && (slot == SLOT_GPIO);
   assign pwm_bus.psel  = psel_i && (slot == SLOT_PWM);
   assign ctrl_bus.psel = psel_i && (slot == SLOT_CTRL);

   assign gpio_bus.penable = penable_i;
   assign gpio_bus.pwrite  = pwrite_i;
   assign gpio_bus.paddr   = paddr_i;
   assign gpio_bus.pwdata  = pwdata_i;

   assign pwm_bus.penable = penable_i;
   assign pwm_bus.pwrite  = pwrite_i;
   assign pwm_bus.paddr   = paddr_i;
   assign pwm_bus.pwdata  = pwdata_i;

   assign ctrl_bus.penable = penable_i;
   assign ctrl_bus.pwrite  = pwrite_i;
   assign ctrl_bus.paddr   = paddr_i;
   assign ctrl_bus.pwdata  = pwdata_i;

   // Response path back to the master
   always_comb begin
      case (slot)
         SLOT_GPIO: begin
            prdata_o  = gpio_bus.prdata;
            pready_o  = gpio_bus.pready;
            pslverr_o = gpio_bus.pslverr;
         end
         SLOT_PWM: begin
            prdata_o  = pwm_bus.prdata;
            pready_o  = pwm_bus.pready;
            pslverr_o = pwm_bus.pslverr;
         end
         SLOT_CTRL: begin
            prdata_o  = ctrl_bus.prdata;
            pready_o  = ctrl_bus.pready;
            pslverr_o = ctrl_bus.pslverr;
         end
         default: begin
            // Unmapped slot completes at once with an error
            prdata_o  = '0;
            pready_o  = 1'b1;
            pslverr_o = psel_i && penable_i;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== apb_gpio_regs.sv ====
`default_nettype none

module apb_gpio_regs (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  apb_periph_pkg::gpio_vec_t gpio_i,
   output apb_periph_pkg::gpio_vec_t gpio_o,
   output apb_periph_pkg::gpio_vec_t gpio_oe_o,
   apb_if.slave                      bus
);
   import apb_periph_pkg::*;

   apb_ofs_t  ofs;
   logic      access;
   logic      ofs_valid;
   logic      err;
   logic      wr_en;
   apb_data_t rdata;
   gpio_vec_t dir_q;
   gpio_vec_t out_q;
   gpio_vec_t sync_q1;
   gpio_vec_t sync_q2;

   assign ofs    = bus.paddr[SLOT_LSB-1:0];
   assign access = bus.psel && bus.penable;

   always_comb begin
      ofs_valid = 1'b1;
      rdata     = '0;
      case (ofs)
         GPIO_DIR_OFS: rdata = apb_data_t'(dir_q);
         GPIO_OUT_OFS: rdata = apb_data_t'(out_q);
         GPIO_IN_OFS:  rdata = apb_data_t'(sync_q2);
         default:      ofs_valid = 1'b0;
      endcase
   end

   // GPIO_IN is read-only
   assign err   = access && (!ofs_valid || (bus.pwrite && (ofs == GPIO_IN_OFS)));
   assign wr_en = access && bus.pwrite && !err;

   assign bus.prdata  = rdata;
   assign bus.pready  = 1'b1;
   assign bus.pslverr = err;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (wr_en) begin
         case (ofs)
            GPIO_DIR_OFS: dir_q <= gpio_vec_t'(bus.pwdata);
            GPIO_OUT_OFS: out_q <= gpio_vec_t'(bus.pwdata);
            default: ;
         endcase
      end
   end

   // Two-stage synchronizer for the asynchronous pad inputs
   always_ff @(posedge clk_i) begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
   end

   assign gpio_oe_o = dir_q;
   assign gpio_o    = out_q;

endmodule

`default_nettype wire

// ==== apb_pwm_timer.sv ====
`default_nettype none

module apb_pwm_timer (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   output logic [apb_periph_pkg::NUM_PWM-1:0] pwm_o,
   apb_if.slave                                bus
);
   import apb_periph_pkg::*;

   localparam int unsigned TH_IDX_W = $clog2(NUM_PWM);
   localparam apb_ofs_t    TH_END   = PWM_TH_OFS + apb_ofs_t'(4 * NUM_PWM);

   apb_ofs_t             ofs;
   logic                 access;
   logic                 ofs_valid;
   logic                 th_hit;
   logic [TH_IDX_W-1:0]  th_idx;
   logic                 err;
   logic                 wr_en;
   apb_data_t            rdata;
   pwm_cnt_t             period_q;
   logic                 en_q;
   pwm_cnt_t             cnt_q;
   pwm_cnt_t             th_q [NUM_PWM];
   logic [NUM_PWM-1:0]   pwm_q;

   assign ofs    = bus.paddr[SLOT_LSB-1:0];
   assign access = bus.psel && bus.penable;
   assign th_hit = (ofs >= PWM_TH_OFS) && (ofs < TH_END) && (ofs[1:0] == 2'b00);
   assign th_idx = ofs[TH_IDX_W+1:2];

   always_comb begin
      ofs_valid = 1'b1;
      rdata     = '0;
      if (th_hit) begin
         rdata = apb_data_t'(th_q[th_idx]);
      end else begin
         case (ofs)
            PWM_PERIOD_OFS: rdata = apb_data_t'(period_q);
            PWM_CTRL_OFS:   rdata = apb_data_t'(en_q);
            PWM_COUNT_OFS:  rdata = apb_data_t'(cnt_q);
            default:        ofs_valid = 1'b0;
         endcase
      end
   end

   assign err   = access && (!ofs_valid || (bus.pwrite && (ofs == PWM_COUNT_OFS)));
   assign wr_en = access && bus.pwrite && !err;

   assign bus.prdata  = rdata;
   assign bus.pready  = 1'b1;
   assign bus.pslverr = err;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         period_q <= '0;
         en_q     <= 1'b0;
         th_q     <= '{default: '0};
      end else if (wr_en) begin
         if (th_hit) begin
            th_q[th_idx] <= pwm_cnt_t'(bus.pwdata);
         end else if (ofs == PWM_PERIOD_OFS) begin
            period_q <= pwm_cnt_t'(bus.pwdata);
         end else if (ofs == PWM_CTRL_OFS) begin
            en_q <= bus.pwdata[0];
         end
      end
   end

   // Counter idles at 0, runs 0 to period-1 while enabled
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !en_q || (period_q == '0)) begin
         cnt_q <= '0;
      end else if (cnt_q >= period_q - pwm_cnt_t'(1)) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + pwm_cnt_t'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pwm_q <= '0;
      end else begin
         for (int i = 0; i < NUM_PWM; i++) begin
            pwm_q[i] <= en_q && (cnt_q < th_q[i]);
         end
      end
   end

   assign pwm_o = pwm_q;

endmodule

`default_nettype wire

// ==== apb_soc_ctrl.sv ====
`default_nettype none

module apb_soc_ctrl (
   input  logic  clk_i,
   input  logic  rst_n_i,
   output logic  cluster_fetch_en_o,
   output logic  cluster_sa_boot_o,
   output logic  cluster_rstn_o,
   apb_if.slave  bus
);
   import apb_periph_pkg::*;

   apb_ofs_t                  ofs;
   logic                      access;
   logic                      ofs_valid;
   logic                      err;
   logic                      wr_en;
   apb_data_t                 rdata;
   logic [CTRL_CL_RSTN_BIT:0] ctrl_q;

   assign ofs    = bus.paddr[SLOT_LSB-1:0];
   assign access = bus.psel && bus.penable;

   always_comb begin
      ofs_valid = 1'b1;
      rdata     = '0;
      case (ofs)
         CTRL_REG_OFS:     rdata = apb_data_t'(ctrl_q);
         CTRL_VERSION_OFS: rdata = CTRL_VERSION;
         default:          ofs_valid = 1'b0;
      endcase
   end

   // Writes to the version word are dropped silently
   assign err   = access && !ofs_valid;
   assign wr_en = access && bus.pwrite && (ofs == CTRL_REG_OFS);

   assign bus.prdata  = rdata;
   assign bus.pready  = 1'b1;
   assign bus.pslverr = err;

   // Cluster stays in reset until software releases it
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (wr_en) begin
         ctrl_q <= bus.pwdata[CTRL_CL_RSTN_BIT:0];
      end
   end

   assign cluster_fetch_en_o = ctrl_q[CTRL_FETCH_BIT];
   assign cluster_sa_boot_o  = ctrl_q[CTRL_SA_BOOT_BIT];
   assign cluster_rstn_o     = ctrl_q[CTRL_CL_RSTN_BIT];

endmodule

`default_nettype wire

// ==== apb_subsystem.sv ====
`default_nettype none

module apb_subsystem (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                psel_i,
   input  logic                                penable_i,
   input  logic                                pwrite_i,
   input  apb_periph_pkg::apb_addr_t           paddr_i,
   input  apb_periph_pkg::apb_data_t           pwdata_i,
   output apb_periph_pkg::apb_data_t           prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o,
   input  apb_periph_pkg::gpio_vec_t           gpio_i,
   output apb_periph_pkg::gpio_vec_t           gpio_o,
   output apb_periph_pkg::gpio_vec_t           gpio_oe_o,
   output logic [apb_periph_pkg::NUM_PWM-1:0] pwm_o,
   output logic                                cluster_fetch_en_o,
   output logic                                cluster_sa_boot_o,
   output logic                                cluster_rstn_o
);

   apb_if gpio_bus ();
   apb_if pwm_bus ();
   apb_if ctrl_bus ();

   apb_periph_demux u_demux (
      .psel_i    ( psel_i    ),
      .penable_i ( penable_i ),
      .pwrite_i  ( pwrite_i  ),
      .paddr_i   ( paddr_i   ),
      .pwdata_i  ( pwdata_i  ),
      .prdata_o  ( prdata_o  ),
      .pready_o  ( pready_o  ),
      .pslverr_o ( pslverr_o ),
      .gpio_bus  ( gpio_bus  ),
      .pwm_bus   ( pwm_bus   ),
      .ctrl_bus  ( ctrl_bus  )
   );

   apb_gpio_regs u_gpio (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .gpio_i    ( gpio_i    ),
      .gpio_o    ( gpio_o    ),
      .gpio_oe_o ( gpio_oe_o ),
      .bus       ( gpio_bus  )
   );

   apb_pwm_timer u_pwm (
      .clk_i   ( clk_i   ),
      .rst_n_i ( rst_n_i ),
      .pwm_o   ( pwm_o   ),
      .bus     ( pwm_bus )
   );

   apb_soc_ctrl u_soc_ctrl (
      .clk_i              ( clk_i              ),
      .rst_n_i            ( rst_n_i            ),
      .cluster_fetch_en_o ( cluster_fetch_en_o ),
      .cluster_sa_boot_o  ( cluster_sa_boot_o  ),
      .cluster_rstn_o     ( cluster_rstn_o     ),
      .bus                ( ctrl_bus           )
   );

endmodule

`default_nettype wire

// ==== apb_subsystem_assertions.sv ====
`default_nettype none

module apb_subsystem_assertions (
   input logic                                clk_i,
   input logic                                rst_n_i,
   input logic                                psel_i,
   input logic                                penable_i,
   input logic                                pready_o,
   input logic                                pslverr_o,
   input logic [apb_periph_pkg::NUM_PWM-1:0] pwm_o,
   input apb_periph_pkg::gpio_vec_t           gpio_oe_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import apb_periph_pkg::*;

   int violations = 0;

   // An error response only completes a transfer
   a_pslverr_with_pready : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_o |-> pready_o && psel_i && penable_i)
      else begin
         $error("pslverr high outside a completing access phase");
         violations++;
      end

   a_setup_before_access : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      penable_i |-> psel_i && $past(psel_i && !penable_i))
      else begin
         $error("penable without a preceding setup cycle");
         violations++;
      end

   a_pwm_idle_after_reset : assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> (pwm_o == '0))
      else begin
         $error("pwm_o not idle in the first cycle after reset");
         violations++;
      end

   a_gpio_oe_after_reset : assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> (gpio_oe_o == '0))
      else begin
         $error("gpio_oe_o not cleared by reset");
         violations++;
      end

endmodule

`default_nettype wire

// ==== tb_apb_subsystem.sv ====
`default_nettype none

module tb_apb_subsystem;
   timeunit 1ns;
   timeprecision 1ps;
   import apb_periph_pkg::*;

   localparam time CLK_PERIOD = 100ns;
   localparam int  WAIT_LIMIT = 16;

   logic               clk_i;
   logic               rst_n_i;
   logic               psel_i;
   logic               penable_i;
   logic               pwrite_i;
   apb_addr_t          paddr_i;
   apb_data_t          pwdata_i;
   apb_data_t          prdata_o;
   logic               pready_o;
   logic               pslverr_o;
   gpio_vec_t          gpio_i;
   gpio_vec_t          gpio_o;
   gpio_vec_t          gpio_oe_o;
   logic [NUM_PWM-1:0] pwm_o;
   logic               cluster_fetch_en_o;
   logic               cluster_sa_boot_o;
   logic               cluster_rstn_o;
   int                 errors;
   int                 checks;

   apb_subsystem u_apb_subsystem (
      .clk_i              ( clk_i              ),
      .rst_n_i            ( rst_n_i            ),
      .psel_i             ( psel_i             ),
      .penable_i          ( penable_i          ),
      .pwrite_i           ( pwrite_i           ),
      .paddr_i            ( paddr_i            ),
      .pwdata_i           ( pwdata_i           ),
      .prdata_o           ( prdata_o           ),
      .pready_o           ( pready_o           ),
      .pslverr_o          ( pslverr_o          ),
      .gpio_i             ( gpio_i             ),
      .gpio_o             ( gpio_o             ),
      .gpio_oe_o          ( gpio_oe_o          ),
      .pwm_o              ( pwm_o              ),
      .cluster_fetch_en_o ( cluster_fetch_en_o ),
      .cluster_sa_boot_o  ( cluster_sa_boot_o  ),
      .cluster_rstn_o     ( cluster_rstn_o     )
   );

   bind apb_subsystem apb_subsystem_assertions u_assertions (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .psel_i    ( psel_i    ),
      .penable_i ( penable_i ),
      .pready_o  ( pready_o  ),
      .pslverr_o ( pslverr_o ),
      .pwm_o     ( pwm_o     ),
      .gpio_oe_o ( gpio_oe_o )
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic apb_addr_t addr_of(input apb_slot_t slot, input apb_ofs_t ofs);
      return {16'h0000, slot, ofs};
   endfunction

   task automatic abort_run(input string why);
      $display("Timeout at %0d ns: %s", $time, why);
      $display("=== FAIL ===");
      $finish;
   endtask

   task automatic check_eq(input string what, input apb_data_t got, input apb_data_t exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // One setup cycle and one access cycle, sampled mid-access
   task automatic apb_transfer(input logic write, input apb_addr_t addr,
                               input apb_data_t wdata, output apb_data_t rdata,
                               output logic err);
      int waits;
      @(negedge clk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = write;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(negedge clk_i);
      penable_i = 1'b1;
      #(CLK_PERIOD / 4);
      waits = 0;
      while (!pready_o && waits < WAIT_LIMIT) begin
         @(negedge clk_i);
         #(CLK_PERIOD / 4);
         waits++;
      end
      if (!pready_o) begin
         abort_run("pready never rose during an APB access phase");
      end else begin
         rdata = prdata_o;
         err   = pslverr_o;
         @(negedge clk_i);
         psel_i    = 1'b0;
         penable_i = 1'b0;
      end
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      apb_data_t unused;
      apb_transfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   task automatic write_ok(input apb_addr_t addr, input apb_data_t data);
      logic err;
      apb_write(addr, data, err);
      check_eq($sformatf("pslverr of write to %h", addr), err, 0);
   endtask

   task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string what);
      apb_data_t rdata;
      logic      err;
      apb_read(addr, rdata, err);
      check_eq({what, " pslverr"}, err, 0);
      check_eq(what, rdata, exp);
   endtask

   task automatic expect_error(input logic write, input apb_addr_t addr,
                               input apb_data_t data, input string what);
      apb_data_t rdata;
      logic      err;
      apb_transfer(write, addr, data, rdata, err);
      check_eq({what, " pslverr"}, err, 1);
   endtask

   task automatic report_test(input string name, input int start);
      $display("Test %s finished with %0d errors", name, errors - start);
   endtask

   task automatic test_reset();
      int start;
      start = errors;
      check_eq("gpio_o", gpio_o, 0);
      check_eq("gpio_oe_o", gpio_oe_o, 0);
      check_eq("pwm_o", pwm_o, 0);
      check_eq("cluster outputs", {cluster_rstn_o, cluster_sa_boot_o, cluster_fetch_en_o}, 0);
      read_expect(addr_of(SLOT_GPIO, GPIO_DIR_OFS), 0, "GPIO DIR");
      read_expect(addr_of(SLOT_GPIO, GPIO_OUT_OFS), 0, "GPIO OUT");
      read_expect(addr_of(SLOT_PWM, PWM_CTRL_OFS), 0, "PWM CTRL");
      read_expect(addr_of(SLOT_CTRL, CTRL_REG_OFS), 0, "CTRL register");
      read_expect(addr_of(SLOT_CTRL, CTRL_VERSION_OFS), CTRL_VERSION, "VERSION");
      report_test("reset values", start);
   endtask

   task automatic test_gpio();
      int        start;
      int        polls;
      gpio_vec_t dir;
      gpio_vec_t out;
      gpio_vec_t pins;
      apb_data_t rdata;
      logic      err;
      start = errors;
      dir   = $urandom;
      out   = $urandom;
      pins  = $urandom;
      write_ok(addr_of(SLOT_GPIO, GPIO_DIR_OFS), dir);
      write_ok(addr_of(SLOT_GPIO, GPIO_OUT_OFS), out);
      check_eq("gpio_oe_o", gpio_oe_o, dir);
      check_eq("gpio_o", gpio_o, out);
      read_expect(addr_of(SLOT_GPIO, GPIO_DIR_OFS), dir, "GPIO DIR");
      read_expect(addr_of(SLOT_GPIO, GPIO_OUT_OFS), out, "GPIO OUT");
      @(negedge clk_i);
      gpio_i = pins;
      // Input passes a two-stage synchronizer, so allow a few reads
      rdata = ~pins;
      polls = 0;
      while (rdata !== pins && polls < 4) begin
         apb_read(addr_of(SLOT_GPIO, GPIO_IN_OFS), rdata, err);
         polls++;
      end
      check_eq("GPIO IN pslverr", err, 0);
      check_eq("GPIO IN", rdata, pins);
      report_test("gpio", start);
   endtask

   task automatic test_pwm();
      int start;
      int period;
      int waits;
      int high_cnt [NUM_PWM];
      int th [NUM_PWM];
      start  = errors;
      period = 4 + ($urandom % 13);
      write_ok(addr_of(SLOT_PWM, PWM_PERIOD_OFS), period);
      for (int i = 0; i < NUM_PWM; i++) begin
         th[i]       = $urandom % (period + 1);
         high_cnt[i] = 0;
         write_ok(addr_of(SLOT_PWM, PWM_TH_OFS + apb_ofs_t'(4 * i)), th[i]);
      end
      write_ok(addr_of(SLOT_PWM, PWM_CTRL_OFS), 1);
      // Counter and registered outputs need two edges to settle
      repeat (3) @(negedge clk_i);
      repeat (period) begin
         @(negedge clk_i);
         for (int i = 0; i < NUM_PWM; i++) begin
            high_cnt[i] += pwm_o[i];
         end
      end
      for (int i = 0; i < NUM_PWM; i++) begin
         check_eq($sformatf("pwm_o[%0d] high cycles", i), high_cnt[i],
                  (th[i] < period) ? th[i] : period);
      end
      write_ok(addr_of(SLOT_PWM, PWM_CTRL_OFS), 0);
      waits = 0;
      while (pwm_o !== '0 && waits < WAIT_LIMIT) begin
         @(negedge clk_i);
         waits++;
      end
      check_eq("pwm_o after disable", pwm_o, 0);
      read_expect(addr_of(SLOT_PWM, PWM_COUNT_OFS), 0, "PWM COUNT after disable");
      report_test("pwm duty", start);
   endtask

   task automatic test_soc_ctrl();
      int start;
      start = errors;
      for (int pat = 0; pat < 8; pat++) begin
         write_ok(addr_of(SLOT_CTRL, CTRL_REG_OFS), pat);
         check_eq("cluster outputs",
                  {cluster_rstn_o, cluster_sa_boot_o, cluster_fetch_en_o}, pat);
         read_expect(addr_of(SLOT_CTRL, CTRL_REG_OFS), pat, "CTRL register");
      end
      write_ok(addr_of(SLOT_CTRL, CTRL_VERSION_OFS), $urandom);
      read_expect(addr_of(SLOT_CTRL, CTRL_VERSION_OFS), CTRL_VERSION, "VERSION after write");
      report_test("soc control", start);
   endtask

   task automatic test_errors();
      int        start;
      apb_data_t dir;
      apb_data_t period;
      apb_data_t ctrl;
      logic      err;
      start = errors;
      apb_read(addr_of(SLOT_GPIO, GPIO_DIR_OFS), dir, err);
      apb_read(addr_of(SLOT_PWM, PWM_PERIOD_OFS), period, err);
      apb_read(addr_of(SLOT_CTRL, CTRL_REG_OFS), ctrl, err);
      expect_error(1'b1, addr_of(4'd3, GPIO_DIR_OFS), ~dir, "write to slot 3");
      expect_error(1'b0, addr_of(4'd15, 12'h000), '0, "read from slot 15");
      expect_error(1'b1, addr_of(SLOT_GPIO, 12'h00C), ~dir, "GPIO undefined offset");
      expect_error(1'b1, addr_of(SLOT_GPIO, GPIO_IN_OFS), ~dir, "write to GPIO IN");
      expect_error(1'b1, addr_of(SLOT_PWM, 12'h00C), ~period, "PWM undefined offset");
      expect_error(1'b1, addr_of(SLOT_CTRL, 12'h008), ~ctrl, "CTRL undefined offset");
      read_expect(addr_of(SLOT_GPIO, GPIO_DIR_OFS), dir, "GPIO DIR after errors");
      read_expect(addr_of(SLOT_PWM, PWM_PERIOD_OFS), period, "PWM PERIOD after errors");
      read_expect(addr_of(SLOT_CTRL, CTRL_REG_OFS), ctrl, "CTRL register after errors");
      report_test("errors", start);
   endtask

   initial begin
      int violations;
      void'($urandom(59));
      errors    = 0;
      checks    = 0;
      clk_i     = 1'b0;
      rst_n_i   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      gpio_i    = '0;
      repeat (8) @(negedge clk_i);
      rst_n_i = 1'b1;
      test_reset();
      test_gpio();
      test_pwm();
      test_soc_ctrl();
      test_errors();
      repeat (2) @(negedge clk_i);
      violations = u_apb_subsystem.u_assertions.violations;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, violations);
      if (errors == 0 && violations == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== apb_subsystem.f ====
apb_periph_pkg.sv
apb_if.sv
apb_periph_demux.sv
apb_gpio_regs.sv
apb_pwm_timer.sv
apb_soc_ctrl.sv
apb_subsystem.sv
apb_subsystem_assertions.sv
tb_apb_subsystem.sv
